//--- verilog/soc_pkg.sv
package soc_pkg;

   //////////////////////////////////////////////////
   // bus widths
   //////////////////////////////////////////////////

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // request from the master, wstrb of zero means read
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [3:0]        wstrb;
   } bus_req_t;

   // response, ready is a single cycle pulse
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } bus_resp_t;

   //////////////////////////////////////////////////
   // address map
   //////////////////////////////////////////////////

   // target select sits in the top two address bits
   localparam int TGT_LSB = ADDR_W - 2;
   // uart register select, word addressed
   localparam int REG_LSB = 2;

   // 00 and 01 both land in sram
   typedef enum logic [1:0] {
      TGT_MEM  = 2'b00,
      TGT_UART = 2'b10,
      TGT_NONE = 2'b11
   } target_e;

   typedef enum logic [1:0] {
      REG_TXDATA = 2'd0,
      REG_STATUS = 2'd1,
      REG_RXDATA = 2'd2,
      REG_RSVD   = 2'd3
   } uart_reg_e;

   // status word bit positions
   localparam int STAT_TX_BUSY  = 0;
   localparam int STAT_RX_VALID = 1;

endpackage

//--- verilog/bus_split.sv
`timescale 1ns/10ps

module bus_split (
   input  logic               clk,
   input  logic               arst_n,
   input  soc_pkg::bus_req_t  m_req,
   output soc_pkg::bus_resp_t m_resp,
   output soc_pkg::bus_req_t  mem_req,
   input  soc_pkg::bus_resp_t mem_resp,
   output soc_pkg::bus_req_t  uart_req,
   input  soc_pkg::bus_resp_t uart_resp
);

   soc_pkg::target_e tgt;
   logic             none_rdy;

   // address decode
   always_comb begin
      case (m_req.addr[soc_pkg::TGT_LSB +: 2])
         2'b10:   tgt = soc_pkg::TGT_UART;
         2'b11:   tgt = soc_pkg::TGT_NONE;
         default: tgt = soc_pkg::TGT_MEM;
      endcase
   end

   // same payload to both targets, only valid is steered
   always_comb begin
      mem_req        = m_req;
      mem_req.valid  = m_req.valid && (tgt == soc_pkg::TGT_MEM);
      uart_req       = m_req;
      uart_req.valid = m_req.valid && (tgt == soc_pkg::TGT_UART);
   end

   //////////////////////////////////////////////////
   // response path
   //////////////////////////////////////////////////

   always_comb begin
      case (tgt)
         soc_pkg::TGT_UART: begin
            m_resp = uart_resp;
         end
         soc_pkg::TGT_NONE: begin
            m_resp.ready = none_rdy;
            m_resp.rdata = '0;
         end
         default: begin
            m_resp = mem_resp;
         end
      endcase
   end

   // unmapped responder
   // fires once, then drops so a held valid gets no second ready
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         none_rdy <= 1'b0;
      end else begin
         none_rdy <= m_req.valid && (tgt == soc_pkg::TGT_NONE) && !none_rdy;
      end
   end

endmodule

//--- verilog/int_mem.sv
`timescale 1ns/10ps

module int_mem #(
   parameter int MEM_ADDR_W = 8
) (
   input  logic               clk,
   input  logic               arst_n,
   input  soc_pkg::bus_req_t  req,
   output soc_pkg::bus_resp_t resp
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;

   logic [soc_pkg::DATA_W-1:0] mem [DEPTH];
   logic [soc_pkg::DATA_W-1:0] rdata_q;
   logic [MEM_ADDR_W-1:0]      widx;
   logic                       pending;
   logic                       access;

   // word index, upper address bits alias
   assign widx   = req.addr[MEM_ADDR_W+1:2];
   // only the first cycle of valid touches the array
   assign access = req.valid && !pending;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= 1'b0;
      end else begin
         pending <= access;
      end
   end

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (access) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[widx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
         // old word on a write, unused by the master
         rdata_q <= mem[widx];
      end
   end

   assign resp = '{ready: pending, rdata: rdata_q};

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
   parameter int BAUD_DIV = 8
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start,
   input  logic [7:0] data,
   input  logic       cts,
   output logic       txd,
   output logic       busy
);

   localparam int               CNT_W = $clog2(BAUD_DIV);
   localparam logic [CNT_W-1:0] LAST  = CNT_W'(BAUD_DIV - 1);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_WAIT_CTS,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   tx_state_e        state;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift;
   logic             bit_end;

   assign bit_end = (baud_cnt == LAST);
   assign busy    = (state != TX_IDLE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         shift    <= '0;
         txd      <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               txd <= 1'b1;
               if (start) begin
                  shift <= data;
                  state <= TX_WAIT_CTS;
               end
            end
            TX_WAIT_CTS: begin
               // peer holds cts high when it cannot take data
               if (!cts) begin
                  state    <= TX_START;
                  baud_cnt <= '0;
                  txd      <= 1'b0;
               end
            end
            TX_START: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_end) begin
                  state    <= TX_DATA;
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  txd      <= shift[0];
               end
            end
            TX_DATA: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_end) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  shift    <= {1'b1, shift[7:1]};
                  if (bit_cnt == 3'd7) begin
                     state <= TX_STOP;
                     txd   <= 1'b1;
                  end else begin
                     // lsb first
                     txd <= shift[1];
                  end
               end
            end
            TX_STOP: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_end) begin
                  state    <= TX_IDLE;
                  baud_cnt <= '0;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
   parameter int BAUD_DIV = 8
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rxd,
   output logic       byte_valid,
   output logic [7:0] data
);

   localparam int               CNT_W = $clog2(BAUD_DIV);
   localparam logic [CNT_W-1:0] HALF  = CNT_W'(BAUD_DIV / 2 - 1);
   localparam logic [CNT_W-1:0] LAST  = CNT_W'(BAUD_DIV - 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   rx_state_e        state;
   logic [2:0]       rxd_sh;
   logic             rxd_s;
   logic             fall;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_cnt;

   // two sync stages, the third flop only for edge detect
   assign rxd_s = rxd_sh[1];
   assign fall  = rxd_sh[2] && !rxd_sh[1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rxd_sh     <= 3'b111;
         state      <= RX_IDLE;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         data       <= '0;
         byte_valid <= 1'b0;
      end else begin
         rxd_sh     <= {rxd_sh[1:0], rxd};
         byte_valid <= 1'b0;
         baud_cnt   <= baud_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (fall) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // half a bit in, line must still be low
               if (baud_cnt == HALF) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rxd_s ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (baud_cnt == LAST) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  data     <= {rxd_s, data[7:1]};
                  if (bit_cnt == 3'd7) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               // framing error drops the byte
               if (baud_cnt == LAST) begin
                  state      <= RX_IDLE;
                  byte_valid <= rxd_s;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- verilog/uart_ctrl.sv
`timescale 1ns/10ps

module uart_ctrl #(
   parameter int BAUD_DIV = 8
) (
   input  logic               clk,
   input  logic               arst_n,
   input  soc_pkg::bus_req_t  req,
   output soc_pkg::bus_resp_t resp,
   output logic               txd,
   input  logic               rxd,
   output logic               rts,
   input  logic               cts
);

   soc_pkg::uart_reg_e         reg_sel;
   logic                       is_write;
   logic                       tx_wr;
   logic                       accept;
   logic                       rdy;
   logic                       tx_start;
   logic                       tx_busy;
   logic                       rd_rx;
   logic                       rx_byte_valid;
   logic [7:0]                 rx_data;
   logic [7:0]                 rx_buf;
   logic                       rx_valid;
   logic [soc_pkg::DATA_W-1:0] status;
   logic [soc_pkg::DATA_W-1:0] rdata_q;

   //////////////////////////////////////////////////
   // bus side
   //////////////////////////////////////////////////

   assign reg_sel  = soc_pkg::uart_reg_e'(req.addr[soc_pkg::REG_LSB +: 2]);
   assign is_write = |req.wstrb;
   assign tx_wr    = req.valid && is_write && (reg_sel == soc_pkg::REG_TXDATA);
   // tx write waits here until the running frame is done
   assign accept   = req.valid && !rdy && !(tx_wr && tx_busy);
   assign tx_start = accept && tx_wr;
   assign rd_rx    = accept && !is_write && (reg_sel == soc_pkg::REG_RXDATA);

   always_comb begin
      status                         = '0;
      status[soc_pkg::STAT_TX_BUSY]  = tx_busy;
      status[soc_pkg::STAT_RX_VALID] = rx_valid;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdy      <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         rdy <= accept;
         // a new byte wins over the read that clears
         if (rx_byte_valid) begin
            rx_valid <= 1'b1;
         end else if (rd_rx) begin
            rx_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_byte_valid) begin
         rx_buf <= rx_data;
      end
      if (accept) begin
         case (reg_sel)
            soc_pkg::REG_STATUS: rdata_q <= status;
            soc_pkg::REG_RXDATA: rdata_q <= {{(soc_pkg::DATA_W-8){1'b0}}, rx_buf};
            soc_pkg::REG_TXDATA,
            soc_pkg::REG_RSVD:   rdata_q <= '0;
         endcase
      end
   end

   assign resp = '{ready: rdy, rdata: rdata_q};
   // low means room for another byte
   assign rts  = rx_valid;

   //////////////////////////////////////////////////
   // serial side
   //////////////////////////////////////////////////

   uart_tx #(
      .BAUD_DIV (BAUD_DIV)
   ) u_uart_tx (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (tx_start),
      .data   (req.wdata[7:0]),
      .cts    (cts),
      .txd    (txd),
      .busy   (tx_busy)
   );

   uart_rx #(
      .BAUD_DIV (BAUD_DIV)
   ) u_uart_rx (
      .clk        (clk),
      .arst_n     (arst_n),
      .rxd        (rxd),
      .byte_valid (rx_byte_valid),
      .data       (rx_data)
   );

endmodule

//--- verilog/soc_system.sv
`timescale 1ns/10ps

module soc_system #(
   parameter int MEM_ADDR_W = 8,
   parameter int BAUD_DIV   = 8
) (
   input  logic               clk,
   input  logic               arst_n,

   // master port
   input  soc_pkg::bus_req_t  bus_req,
   output soc_pkg::bus_resp_t bus_resp,

   // serial lines
   output logic               uart_txd,
   input  logic               uart_rxd,
   output logic               uart_rts,
   input  logic               uart_cts
);

   soc_pkg::bus_req_t  mem_req;
   soc_pkg::bus_resp_t mem_resp;
   soc_pkg::bus_req_t  uart_req;
   soc_pkg::bus_resp_t uart_resp;

   //////////////////////////////////////////////////
   // interconnect
   //////////////////////////////////////////////////

   bus_split u_bus_split (
      .clk       (clk),
      .arst_n    (arst_n),
      .m_req     (bus_req),
      .m_resp    (bus_resp),
      .mem_req   (mem_req),
      .mem_resp  (mem_resp),
      .uart_req  (uart_req),
      .uart_resp (uart_resp)
   );

   //////////////////////////////////////////////////
   // targets
   //////////////////////////////////////////////////

   int_mem #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) u_int_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .resp   (mem_resp)
   );

   uart_ctrl #(
      .BAUD_DIV (BAUD_DIV)
   ) u_uart_ctrl (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (uart_req),
      .resp   (uart_resp),
      .txd    (uart_txd),
      .rxd    (uart_rxd),
      .rts    (uart_rts),
      .cts    (uart_cts)
   );

endmodule

//--- sim/soc_system_properties.sv
`timescale 1ns/10ps

module soc_system_properties (
   input logic               clk,
   input logic               arst_n,
   input soc_pkg::bus_req_t  bus_req,
   input soc_pkg::bus_resp_t bus_resp,
   input logic               uart_txd,
   input logic               uart_rts,
   input logic               tx_busy
);

   //////////////////////////////////////////////////
   // bus handshake
   //////////////////////////////////////////////////

   a_ready_needs_valid : assert property (@(posedge clk) disable iff (!arst_n)
      bus_resp.ready |-> bus_req.valid)
      else $error("bus ready without a valid request");

   a_ready_single : assert property (@(posedge clk) disable iff (!arst_n)
      bus_resp.ready |=> !bus_resp.ready)
      else $error("bus ready held for two cycles");

   //////////////////////////////////////////////////
   // uart lines
   //////////////////////////////////////////////////

   a_reset_lines : assert property (@(posedge clk)
      !arst_n |-> (uart_txd && !uart_rts))
      else $error("uart lines wrong during reset");

   // idle transmitter keeps the line at mark level
   a_txd_idle : assert property (@(posedge clk) disable iff (!arst_n)
      !tx_busy |-> uart_txd)
      else $error("uart_txd low while transmitter idle");

endmodule

bind soc_system soc_system_properties u_soc_system_properties (
   .clk      (clk),
   .arst_n   (arst_n),
   .bus_req  (bus_req),
   .bus_resp (bus_resp),
   .uart_txd (uart_txd),
   .uart_rts (uart_rts),
   .tx_busy  (u_uart_ctrl.tx_busy)
);

//--- sim/soc_system_tb.sv
`timescale 1ns/10ps

module soc_system_tb;

   localparam int MEM_ADDR_W   = 8;
   localparam int BAUD_DIV     = 8;
   localparam int BUS_TIMEOUT  = 200;
   localparam int BYTE_TIMEOUT = 300;
   localparam int RTS_TIMEOUT  = 40;

   logic               clk;
   logic               arst_n;
   soc_pkg::bus_req_t  bus_req;
   soc_pkg::bus_resp_t bus_resp;
   logic               uart_txd;
   logic               uart_rxd;
   logic               uart_rts;
   logic               uart_cts;

   logic [7:0]         lfsr;
   logic [7:0]         tx_bytes [$];
   logic               mon_busy;
   int                 mon_cnt;
   logic [7:0]         mon_byte;

   soc_system #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .BAUD_DIV   (BAUD_DIV)
   ) u_soc_system (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus_req  (bus_req),
      .bus_resp (bus_resp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compare_resp(input string name, input soc_pkg::bus_resp_t expected,
                               input soc_pkg::bus_resp_t actual);
      if (actual !== expected) begin
         fail_stop($sformatf("** Error: %s expected %h actual %h (ready %b)",
                             name, expected.rdata, actual.rdata, actual.ready));
      end
   endtask

   task automatic compare_byte(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
      if (actual !== expected) begin
         fail_stop($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic compare_line(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         fail_stop($sformatf("** Error: %s expected %b actual %b", name, expected, actual));
      end
   endtask

   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
      lfsr = {lfsr[6:0], fb};
      return fb;
   endfunction

   task automatic idle_gap();
      logic [1:0] gap;
      gap = {lfsr_bit(), lfsr_bit()};
      repeat (gap) begin
         @(posedge clk);
         #2;
      end
   endtask

   //////////////////////////////////////////////////
   // bus master and uart line model
   //////////////////////////////////////////////////

   // entered just after a rising edge, so a zero gap keeps valid high
   task automatic bus_access(input string name, input logic [15:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output soc_pkg::bus_resp_t resp);
      int cycles;
      bus_req.valid = 1'b1;
      bus_req.addr  = addr;
      bus_req.wdata = wdata;
      bus_req.wstrb = wstrb;
      cycles = 0;
      @(negedge clk);
      while (!bus_resp.ready) begin
         if (cycles == BUS_TIMEOUT) begin
            fail_stop($sformatf("case %s timed out waiting for bus ready", name));
         end
         cycles++;
         @(negedge clk);
      end
      resp = bus_resp;
      @(posedge clk);
      #2;
      bus_req = '0;
   endtask

   // called on every falling clock edge to sample near mid-bit
   task automatic sample_txd();
      if (!mon_busy) begin
         if (uart_txd == 1'b0) begin
            mon_busy = 1'b1;
            mon_cnt  = 0;
         end
      end else begin
         mon_cnt++;
         if (mon_cnt == BAUD_DIV / 2) begin
            compare_line("txd start bit", 1'b0, uart_txd);
         end else if (mon_cnt == BAUD_DIV / 2 + 9 * BAUD_DIV) begin
            compare_line("txd stop bit", 1'b1, uart_txd);
            tx_bytes.push_back(mon_byte);
            mon_busy = 1'b0;
         end else if ((mon_cnt - BAUD_DIV / 2) % BAUD_DIV == 0) begin
            // lsb arrives first
            mon_byte = {uart_txd, mon_byte[7:1]};
         end
      end
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         sample_txd();
      end
   end

   task automatic send_frame(input logic [7:0] value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #2;
         uart_rxd = frame[i];
         repeat (BAUD_DIV - 1) @(posedge clk);
      end
   endtask

   task automatic wait_txd_byte(input string name, input logic [7:0] expected);
      int         cycles;
      logic [7:0] got;
      cycles = 0;
      while (tx_bytes.size() == 0) begin
         if (cycles == BYTE_TIMEOUT) begin
            fail_stop($sformatf("case %s timed out waiting for a frame on uart_txd", name));
         end
         cycles++;
         @(negedge clk);
      end
      got = tx_bytes.pop_front();
      compare_byte(name, expected, got);
   endtask

   task automatic wait_rts(input string name);
      int cycles;
      cycles = 0;
      while (!uart_rts) begin
         if (cycles == RTS_TIMEOUT) begin
            fail_stop($sformatf("case %s timed out waiting for uart_rts to go high", name));
         end
         cycles++;
         @(negedge clk);
      end
   endtask

   task automatic run_case(input string name, input logic [7:0] op, input logic [15:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb,
                           input logic [31:0] exp_val);
      soc_pkg::bus_resp_t resp;
      soc_pkg::bus_resp_t expected;
      case (op)
         "W": begin
            bus_access(name, addr, wdata, wstrb, resp);
            idle_gap();
         end
         "R": begin
            bus_access(name, addr, wdata, wstrb, resp);
            expected = '{ready: 1'b1, rdata: exp_val};
            compare_resp(name, expected, resp);
            idle_gap();
         end
         "T": begin
            wait_txd_byte(name, exp_val[7:0]);
            // back in step with the bus driver
            @(posedge clk);
            #2;
         end
         "X": begin
            compare_line(name, 1'b0, uart_rts);
            send_frame(wdata[7:0]);
            wait_rts(name);
            @(posedge clk);
            #2;
         end
         "C": begin
            // addr holds the idle cycles before the new cts level
            repeat (addr) begin
               @(negedge clk);
               compare_line(name, 1'b1, uart_txd);
            end
            @(posedge clk);
            #2;
            uart_cts = wdata[0];
         end
         default: begin
            fail_stop($sformatf("case %s has an unknown opcode", name));
         end
      endcase
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      int            fd;
      int            n;
      int            cases;
      logic [127:0]  name;
      logic [7:0]    op;
      logic [15:0]   addr;
      logic [31:0]   wdata;
      logic [3:0]    wstrb;
      logic [31:0]   exp_val;
      clk      = 1'b0;
      arst_n   = 1'b1;
      bus_req  = '0;
      uart_rxd = 1'b1;
      uart_cts = 1'b0;
      lfsr     = 8'd28;
      mon_busy = 1'b0;
      mon_cnt  = 0;
      mon_byte = '0;
      cases    = 0;
      #2;
      arst_n = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      arst_n = 1'b1;
      compare_line("reset txd", 1'b1, uart_txd);
      compare_line("reset rts", 1'b0, uart_rts);

      fd = $fopen("sim/soc_cases.txt", "r");
      if (fd == 0) begin
         fail_stop("could not open sim/soc_cases.txt");
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, "%s %s %h %h %h %h\n", name, op, addr, wdata, wstrb, exp_val);
         if (n == 6) begin
            run_case($sformatf("%0s", name), op, addr, wdata, wstrb, exp_val);
            cases++;
         end else if (!$feof(fd)) begin
            fail_stop("malformed line in sim/soc_cases.txt");
         end
      end
      $fclose(fd);

      if (cases == 0) begin
         fail_stop("no cases were read from sim/soc_cases.txt");
      end else if (tx_bytes.size() != 0 || mon_busy) begin
         fail_stop("uart_txd carried a frame that no case expected");
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

//--- sim/soc_cases.txt
reset_status R 8004 00000000 0 00000000
mem_wr0 W 0000 01234567 f 00000000
mem_wr1 W 0004 89abcdef f 00000000
mem_wr2 W 0010 cafef00d f 00000000
mem_rd0 R 0000 00000000 0 01234567
mem_rd1 R 0004 00000000 0 89abcdef
mem_rd2 R 0010 00000000 0 cafef00d
mem_full W 0020 11223344 f 00000000
mem_strb5 W 0020 aabbccdd 5 00000000
mem_strb_rd R 0020 00000000 0 11bb33dd
mem_strb8 W 0020 55667788 8 00000000
mem_strb_rd2 R 0020 00000000 0 55bb33dd
alias_rd0 R 0410 00000000 0 cafef00d
alias_rd1 R 2404 00000000 0 89abcdef
alias_rd2 R 4000 00000000 0 01234567
none_rd R c000 00000000 0 00000000
none_wr W c010 deadbeef f 00000000
none_rd2 R fffc 00000000 0 00000000
none_chk R 0010 00000000 0 cafef00d
tx_wr W 8000 123456a5 1 00000000
tx_busy R 8004 00000000 0 00000001
tx_byte T 0000 00000000 0 000000a5
tx_wr_a W 8000 00000041 1 00000000
tx_wr_b W 8000 00000042 1 00000000
tx_byte_a T 0000 00000000 0 00000041
tx_byte_b T 0000 00000000 0 00000042
cts_hold C 0000 00000001 0 00000000
cts_wr W 8000 0000005a 1 00000000
cts_busy R 8004 00000000 0 00000001
cts_free C 0030 00000000 0 00000000
cts_byte T 0000 00000000 0 0000005a
rx_byte X 0000 0000003c 0 00000000
rx_status R 8004 00000000 0 00000002
rx_data R 8008 00000000 0 0000003c
rx_clear R 8004 00000000 0 00000000
rx_byte2 X 0000 000000c3 0 00000000
rx_data2 R 8008 00000000 0 000000c3
rsvd_rd R 800c 00000000 0 00000000

//--- sim.f
verilog/soc_pkg.sv
verilog/bus_split.sv
verilog/int_mem.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_ctrl.sv
verilog/soc_system.sv
sim/soc_system_properties.sv
sim/soc_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the soc_system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module soc_system_tb

# status comes from grep, so a missing pass line stops the script
./obj_dir/Vsoc_system_tb | tee /dev/stderr | grep -F "Simulation completed successfully" > /dev/null
echo "run_sim: pass line found"
